// ==== dv/imem_model.sv ====
`timescale 1ns/1ns

module imem_model (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_i,
    input  fetch_pkg::line_addr_t addr_i,
    output logic                  rsp_o,
    output fetch_pkg::line_t      data_o,
    output logic                  busy_o
);
    import fetch_pkg::*;

    integer     seed = 84;
    int         wait_cycles;
    int         count_q;
    line_addr_t line_q;

    // low byte of the byte address
    function automatic logic [7:0] pattern_byte(input addr_t a);
        return a[7:0];
    endfunction

    function automatic line_t line_pattern(input line_addr_t l);
        line_t data;
        addr_t base;
        base = {l, 4'h0};
        for (int k = 0; k < LINE_BYTES; k++) begin
            data[8*k +: 8] = pattern_byte(base + addr_t'(k));
        end
        return data;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // response timing, 1 to 4 cycles after the request
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset_i) begin
            rsp_o   <= 1'b0;
            busy_o  <= 1'b0;
            data_o  <= '0;
            count_q <= 0;
            line_q  <= '0;
        end else begin
            rsp_o <= 1'b0;
            if (req_i) begin
                wait_cycles = $unsigned($random(seed)) % 4;
                line_q <= addr_i;
                if (wait_cycles == 0) begin
                    rsp_o  <= 1'b1;
                    data_o <= line_pattern(addr_i);
                end else begin
                    busy_o  <= 1'b1;
                    count_q <= wait_cycles - 1;
                end
            end else if (busy_o) begin
                if (count_q == 0) begin
                    rsp_o  <= 1'b1;
                    data_o <= line_pattern(line_q);
                    busy_o <= 1'b0;
                end else begin
                    count_q <= count_q - 1;
                end
            end
        end
    end

endmodule

// ==== dv/tb_fetch_top.sv ====
`timescale 1ns/1ns

module tb_fetch_top;
    import fetch_pkg::*;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       init_i;
    addr_t      init_addr_i;
    logic       resteer_i;
    addr_t      resteer_addr_i;
    logic       br_taken_i;
    addr_t      br_target_i;
    logic       mem_req_o;
    line_addr_t mem_addr_o;
    logic       mem_rsp_i;
    line_t      mem_data_i;
    line_t      packet_o;
    logic       packet_valid_o;
    len_t       length_i = 4'd1;
    logic       stall_i;
    logic       mem_busy;

    integer     seed = 84;
    int         errors = 0;
    int         timeouts = 0;
    int         adv_count;
    logic       seen_redirect;
    addr_t      exp_addr;
    line_t      exp_packet;
    logic       prev_hold;
    line_t      prev_packet;

    always #5 clk = ~clk;

    fetch_top i_dut (.*);

    imem_model i_mem (
        .clk    (clk),
        .reset_i(reset_i),
        .req_i  (mem_req_o),
        .addr_i (mem_addr_o),
        .rsp_o  (mem_rsp_i),
        .data_o (mem_data_i),
        .busy_o (mem_busy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference pointer and expected packet
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset_i) begin
            exp_addr      <= '0;
            adv_count     <= 0;
            seen_redirect <= 1'b0;
        end else if (init_i || resteer_i || br_taken_i) begin
            // init, then resteer, then taken branch
            exp_addr      <= init_i ? init_addr_i : (resteer_i ? resteer_addr_i : br_target_i);
            seen_redirect <= 1'b1;
        end else if (packet_valid_o && !stall_i) begin
            exp_addr  <= exp_addr + addr_t'(length_i);
            adv_count <= adv_count + 1;
        end
        prev_hold   <= packet_valid_o && stall_i && !(init_i || resteer_i || br_taken_i);
        prev_packet <= packet_o;
        // decode reports a new length every cycle
        length_i    <= len_t'(1 + ($unsigned($random(seed)) % 15));
    end

    // each byte holds the low byte of its own address
    always_comb begin
        for (int k = 0; k < LINE_BYTES; k++) begin
            exp_packet[8*k +: 8] = 8'(exp_addr + addr_t'(k));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_quiet_req: assert property (@(posedge clk) disable iff (reset_i)
        !seen_redirect |-> !mem_req_o)
        else begin
            errors++;
            $display("Fail at %0t: mem_req_o expected 0, got %b", $time, mem_req_o);
        end

    a_quiet_packet: assert property (@(posedge clk) disable iff (reset_i)
        !seen_redirect |-> !packet_valid_o)
        else begin
            errors++;
            $display("Fail at %0t: packet_valid_o expected 0, got %b", $time, packet_valid_o);
        end

    // one line in flight at a time
    a_one_outstanding: assert property (@(posedge clk) disable iff (reset_i)
        (mem_busy || mem_rsp_i) |-> !mem_req_o)
        else begin
            errors++;
            $display("Fail at %0t: mem_req_o expected 0, got %b", $time, mem_req_o);
        end

    // requests stay inside the four-line window that starts at the packet line
    a_req_window: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o |-> (line_addr_t'(mem_addr_o - exp_addr[31:4]) < 28'd4))
        else begin
            errors++;
            $display("Fail at %0t: mem_addr_o expected %h to %h, got %h", $time,
                     exp_addr[31:4], line_addr_t'(exp_addr[31:4] + 28'd3), mem_addr_o);
        end

    a_stream: assert property (@(posedge clk) disable iff (reset_i)
        packet_valid_o |-> (packet_o == exp_packet))
        else begin
            errors++;
            $display("Fail at %0t: packet_o expected %h, got %h", $time, exp_packet, packet_o);
        end

    // stalled packet stays put
    a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
        prev_hold |-> (packet_valid_o && packet_o == prev_packet))
        else begin
            errors++;
            $display("Fail at %0t: packet_o expected %h, got %h (packet_valid_o %b)",
                     $time, prev_packet, packet_o, packet_valid_o);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_redirect(input logic i, input addr_t ia, input logic r,
                                  input addr_t ra, input logic b, input addr_t ba);
        init_i         <= i;
        init_addr_i    <= ia;
        resteer_i      <= r;
        resteer_addr_i <= ra;
        br_taken_i     <= b;
        br_target_i    <= ba;
        @(posedge clk);
        init_i     <= 1'b0;
        resteer_i  <= 1'b0;
        br_taken_i <= 1'b0;
    endtask

    task automatic run_advances(input int n);
        int start;
        int cycles;
        start  = adv_count;
        cycles = 0;
        @(negedge clk);
        while (adv_count - start < n && cycles < 40 * n) begin
            @(negedge clk);
            cycles++;
        end
        if (adv_count - start < n) begin
            timeouts++;
            $display("timeout: packet stream stopped after %0d of %0d advances",
                     adv_count - start, n);
        end
        @(posedge clk);
    endtask

    task automatic wait_mem_busy();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!mem_busy && cycles < 60) begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_busy) begin
            timeouts++;
            $display("timeout: no memory request went outstanding");
        end
        @(posedge clk);
    endtask

    initial begin
        reset_i        = 1'b1;
        init_i         = 1'b0;
        init_addr_i    = '0;
        resteer_i      = 1'b0;
        resteer_addr_i = '0;
        br_taken_i     = 1'b0;
        br_target_i    = '0;
        stall_i        = 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        // nothing may move before the first redirect
        repeat (12) @(posedge clk);

        apply_redirect(1'b1, 32'h0000_1000, 1'b0, '0, 1'b0, '0);
        run_advances(60);
        apply_redirect(1'b1, 32'h0000_2007, 1'b0, '0, 1'b0, '0);
        run_advances(40);
        apply_redirect(1'b0, '0, 1'b0, '0, 1'b1, 32'h0000_305b);
        run_advances(40);

        // resteer with a line in flight
        for (int i = 0; i < 4; i++) begin
            wait_mem_busy();
            apply_redirect(1'b0, '0, 1'b1, 32'h0000_4a3c + 32'h1d3 * i, 1'b0, '0);
            run_advances(20);
        end

        // same-cycle redirects
        apply_redirect(1'b0, '0, 1'b1, 32'h0000_5123, 1'b1, 32'h0000_6010);
        run_advances(30);
        apply_redirect(1'b1, 32'h0000_7ff5, 1'b1, 32'h0000_0a10, 1'b1, 32'h0000_0b20);
        run_advances(30);
        apply_redirect(1'b1, 32'h00c0_ffee, 1'b0, '0, 1'b1, 32'h0000_0d00);
        run_advances(30);

        // stall while the buffer fills, then mid stream
        apply_redirect(1'b1, 32'h0000_8009, 1'b0, '0, 1'b0, '0);
        stall_i <= 1'b1;
        repeat (20) @(posedge clk);
        stall_i <= 1'b0;
        run_advances(10);
        stall_i <= 1'b1;
        repeat (8) @(posedge clk);
        stall_i <= 1'b0;
        run_advances(30);

        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/fetch_pkg.sv
source/fetch_addr_gen.sv
source/line_buffer.sv
source/packet_aligner.sv
source/fetch_top.sv
dv/imem_model.sv
dv/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_top -f filelist.f -o sim_fetch

./obj_dir/sim_fetch | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== source/fetch_addr_gen.sv ====
`timescale 1ns/1ns

module fetch_addr_gen (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            init_i,
    input  fetch_pkg::addr_t                init_addr_i,
    input  logic                            resteer_i,
    input  fetch_pkg::addr_t                resteer_addr_i,
    input  logic                            br_taken_i,
    input  fetch_pkg::addr_t                br_target_i,
    input  logic [fetch_pkg::NUM_SLOTS-1:0] slot_valid_i,
    input  logic                            mem_rsp_i,
    input  fetch_pkg::line_t                mem_data_i,
    output logic                            mem_req_o,
    output fetch_pkg::line_addr_t           mem_addr_o,
    output logic                            flush_o,
    output fetch_pkg::bip_t                 flush_bip_o,
    output logic                            wr_o,
    output fetch_pkg::slot_t                wr_slot_o,
    output fetch_pkg::line_t                wr_data_o
);
    import fetch_pkg::*;

    fetch_state_e state_q;
    line_addr_t   fip_q;
    slot_t        req_slot_q;
    logic         discard_q;
    logic         active_q;
    logic         redirect;
    addr_t        target;
    slot_t        fip_slot;

    // init beats resteer beats taken branch
    always_comb begin
        redirect = init_i | resteer_i | br_taken_i;
        if (init_i) begin
            target = init_addr_i;
        end else if (resteer_i) begin
            target = resteer_addr_i;
        end else begin
            target = br_target_i;
        end
    end

    assign fip_slot    = fip_q[1:0];
    assign flush_o     = redirect;
    assign flush_bip_o = target[5:0];

    // fetch only after the first redirect, into a free slot
    assign mem_req_o  = active_q && (state_q == FS_IDLE) && !slot_valid_i[fip_slot] && !redirect;
    assign mem_addr_o = fip_q;

    // stale responses are dropped
    assign wr_o      = mem_rsp_i && (state_q == FS_WAIT) && !discard_q && !redirect;
    assign wr_slot_o = req_slot_q;
    assign wr_data_o = mem_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= FS_IDLE;
            fip_q      <= '0;
            req_slot_q <= '0;
            discard_q  <= 1'b0;
            active_q   <= 1'b0;
        end else begin
            if (redirect) begin
                fip_q    <= target[31:4];
                active_q <= 1'b1;
            end else if (wr_o) begin
                fip_q <= fip_q + 1'b1;
            end

            case (state_q)
                FS_IDLE: begin
                    if (mem_req_o) begin
                        state_q    <= FS_WAIT;
                        req_slot_q <= fip_slot;
                    end
                end
                FS_WAIT: begin
                    if (mem_rsp_i) begin
                        state_q   <= FS_IDLE;
                        discard_q <= 1'b0;
                    end else if (redirect) begin
                        // line in flight now belongs to the old stream
                        discard_q <= 1'b1;
                    end
                end
                default: state_q <= FS_IDLE;
            endcase
        end
    end

    // accepted line lands in the slot the fip still points at
    a_wr_fip_slot: assert property (@(posedge clk) disable iff (reset_i)
        wr_o |-> (req_slot_q == fip_slot));

    // memory only answers an outstanding request
    a_no_rsp_in_idle: assert property (@(posedge clk) disable iff (reset_i)
        mem_rsp_i |-> (state_q == FS_WAIT));

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////////////////////////////////////////

    // four line slots, indexed by line address bits 1:0
    localparam int NUM_SLOTS  = 4;
    localparam int LINE_BYTES = 16;

    ////////////////////////////////////////////////////////////////////////////
    // address and data types
    ////////////////////////////////////////////////////////////////////////////

    // byte address
    typedef logic [31:0] addr_t;

    // address bits 31:4
    typedef logic [27:0] line_addr_t;

    // byte k in bits 8k+7:8k
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // slot in bits 5:4, offset in bits 3:0
    typedef logic [5:0] bip_t;

    typedef logic [1:0] slot_t;

    // decode length, 1 to 15
    typedef logic [3:0] len_t;

    ////////////////////////////////////////////////////////////////////////////
    // request FSM
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        FS_IDLE,
        FS_WAIT
    } fetch_state_e;

endpackage

// ==== source/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    input  logic                  clk,
    input  logic                  reset_i,

    // redirects from the core
    input  logic                  init_i,
    input  fetch_pkg::addr_t      init_addr_i,
    input  logic                  resteer_i,
    input  fetch_pkg::addr_t      resteer_addr_i,
    input  logic                  br_taken_i,
    input  fetch_pkg::addr_t      br_target_i,

    // instruction memory port
    output logic                  mem_req_o,
    output fetch_pkg::line_addr_t mem_addr_o,
    input  logic                  mem_rsp_i,
    input  fetch_pkg::line_t      mem_data_i,

    // decode port
    output fetch_pkg::line_t      packet_o,
    output logic                  packet_valid_o,
    input  fetch_pkg::len_t       length_i,
    input  logic                  stall_i
);
    import fetch_pkg::*;

    logic                 flush;
    bip_t                 flush_bip;
    logic                 wr;
    slot_t                wr_slot;
    line_t                wr_data;
    logic [NUM_SLOTS-1:0] slot_valid;
    line_t                line0;
    line_t                line1;
    line_t                line2;
    line_t                line3;
    logic                 rel;
    slot_t                rel_slot;

    ////////////////////////////////////////////////////////////////////////////
    // fip and line requests
    ////////////////////////////////////////////////////////////////////////////

    fetch_addr_gen i_addr_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .init_i        (init_i),
        .init_addr_i   (init_addr_i),
        .resteer_i     (resteer_i),
        .resteer_addr_i(resteer_addr_i),
        .br_taken_i    (br_taken_i),
        .br_target_i   (br_target_i),
        .slot_valid_i  (slot_valid),
        .mem_rsp_i     (mem_rsp_i),
        .mem_data_i    (mem_data_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .flush_o       (flush),
        .flush_bip_o   (flush_bip),
        .wr_o          (wr),
        .wr_slot_o     (wr_slot),
        .wr_data_o     (wr_data)
    );

    // slots 00 to 11
    line_buffer i_line_buffer (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush),
        .wr_i          (wr),
        .wr_slot_i     (wr_slot),
        .wr_data_i     (wr_data),
        .release_i     (rel),
        .release_slot_i(rel_slot),
        .slot_valid_o  (slot_valid),
        .line0_o       (line0),
        .line1_o       (line1),
        .line2_o       (line2),
        .line3_o       (line3)
    );

    ////////////////////////////////////////////////////////////////////////////
    // bip and packet to decode
    ////////////////////////////////////////////////////////////////////////////

    packet_aligner i_aligner (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush),
        .flush_bip_i   (flush_bip),
        .slot_valid_i  (slot_valid),
        .line0_i       (line0),
        .line1_i       (line1),
        .line2_i       (line2),
        .line3_i       (line3),
        .length_i      (length_i),
        .stall_i       (stall_i),
        .packet_o      (packet_o),
        .packet_valid_o(packet_valid_o),
        .release_o     (rel),
        .release_slot_o(rel_slot)
    );

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            flush_i,
    input  logic                            wr_i,
    input  fetch_pkg::slot_t                wr_slot_i,
    input  fetch_pkg::line_t                wr_data_i,
    input  logic                            release_i,
    input  fetch_pkg::slot_t                release_slot_i,
    output logic [fetch_pkg::NUM_SLOTS-1:0] slot_valid_o,
    output fetch_pkg::line_t                line0_o,
    output fetch_pkg::line_t                line1_o,
    output fetch_pkg::line_t                line2_o,
    output fetch_pkg::line_t                line3_o
);
    import fetch_pkg::*;

    logic [NUM_SLOTS-1:0] valid_q;
    line_t                line_q [NUM_SLOTS];

    ////////////////////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= '0;
        end else begin
            if (wr_i) begin
                valid_q[wr_slot_i] <= 1'b1;
            end
            // aligner releases the slot it just left
            if (release_i) begin
                valid_q[release_slot_i] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // line storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_i) begin
            line_q[wr_slot_i] <= wr_data_i;
        end
    end

    assign slot_valid_o = valid_q;
    assign line0_o      = line_q[0];
    assign line1_o      = line_q[1];
    assign line2_o      = line_q[2];
    assign line3_o      = line_q[3];

    // fetch must not overwrite a line the aligner still reads
    a_wr_free_slot: assert property (@(posedge clk) disable iff (reset_i)
        wr_i |-> !valid_q[wr_slot_i]);

endmodule

// ==== source/packet_aligner.sv ====
`timescale 1ns/1ns

module packet_aligner (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            flush_i,
    input  fetch_pkg::bip_t                 flush_bip_i,
    input  logic [fetch_pkg::NUM_SLOTS-1:0] slot_valid_i,
    input  fetch_pkg::line_t                line0_i,
    input  fetch_pkg::line_t                line1_i,
    input  fetch_pkg::line_t                line2_i,
    input  fetch_pkg::line_t                line3_i,
    input  fetch_pkg::len_t                 length_i,
    input  logic                            stall_i,
    output fetch_pkg::line_t                packet_o,
    output logic                            packet_valid_o,
    output logic                            release_o,
    output fetch_pkg::slot_t                release_slot_o
);
    import fetch_pkg::*;

    bip_t                      bip_q;
    bip_t                      bip_next;
    slot_t                     cur_slot;
    slot_t                     nxt_slot;
    logic [3:0]                offset;
    logic                      advance;
    line_t                     lines [NUM_SLOTS];
    logic [2*LINE_BYTES*8-1:0] window;

    assign lines[0] = line0_i;
    assign lines[1] = line1_i;
    assign lines[2] = line2_i;
    assign lines[3] = line3_i;

    ////////////////////////////////////////////////////////////////////////////
    // packet extraction
    ////////////////////////////////////////////////////////////////////////////

    assign cur_slot = bip_q[5:4];
    assign nxt_slot = cur_slot + 1'b1;
    assign offset   = bip_q[3:0];

    // current line low, following line high
    assign window = {lines[nxt_slot], lines[cur_slot]};

    // 16 bytes from the bip offset
    assign packet_o = line_t'(window >> {offset, 3'b000});

    // packet may span into the next line, so both must be present
    assign packet_valid_o = slot_valid_i[cur_slot] && slot_valid_i[nxt_slot];

    ////////////////////////////////////////////////////////////////////////////
    // bip advance and slot release
    ////////////////////////////////////////////////////////////////////////////

    assign advance  = packet_valid_o && !stall_i;
    // wraps around the 64 byte window
    assign bip_next = bip_q + bip_t'(length_i);

    // length of at most 15 crosses at most one line boundary
    assign release_o      = advance && (bip_next[5:4] != cur_slot);
    assign release_slot_o = cur_slot;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bip_q <= '0;
        end else if (flush_i) begin
            bip_q <= flush_bip_i;
        end else if (advance) begin
            bip_q <= bip_next;
        end
    end

    // zero length would stall the stream without a stall request
    a_len_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        advance |-> (length_i != '0));

endmodule
